// File: eth_crc32.sv
`timescale 1ns/1ps
`default_nettype none

module eth_crc32 (
    input  wire         clk_i,
    input  wire         rst_i,
    input  wire         clear_i,
    input  wire         en_i,
    input  wire  [7:0]  data_i,
    output logic [31:0] crc_o
);

    logic [31:0] crc_q;
    logic [31:0] crc_next;

    // lsb-first byte update
    always_comb begin
        crc_next = crc_q ^ {24'h000000, data_i};
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0]) begin
                crc_next = (crc_next >> 1) ^ udp_tx_pkg::CRC32_POLY_REFL;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || clear_i) begin
            crc_q <= 32'hFFFF_FFFF;
        end else if (en_i) begin
            crc_q <= crc_next;
        end
    end

    // final xor, byte 0 of the fcs is crc_o[7:0]
    assign crc_o = ~crc_q;

endmodule

`default_nettype wire

// File: frame_tx_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module frame_tx_ctrl (
    input  wire                               clk_i,
    input  wire                               rst_i,
    input  wire                               pkt_avail_i,
    input  wire [udp_tx_pkg::LEN_WIDTH-1:0]   pkt_len_i,
    output logic                              len_pop_o,
    output logic                              byte_pop_o,
    input  wire [7:0]                         byte_i,
    input  wire udp_tx_pkg::frame_hdr_t       hdr_i,
    output logic                              crc_clear_o,
    output logic                              crc_en_o,
    output logic [7:0]                        crc_data_o,
    input  wire [31:0]                        crc_i,
    output udp_tx_pkg::gmii_tx_t              gmii_o
);

    udp_tx_pkg::tx_state_e state_q;
    udp_tx_pkg::tx_state_e state_d;

    logic [udp_tx_pkg::LEN_WIDTH-1:0] cnt_q;
    logic [udp_tx_pkg::LEN_WIDTH-1:0] len_q;
    logic [udp_tx_pkg::LEN_WIDTH-1:0] state_bytes;
    logic                             state_done;

    logic [$bits(udp_tx_pkg::frame_hdr_t)-1:0] hdr_sr;
    logic [31:0] fcs_q;

    logic       tx_en;
    logic [7:0] tx_d;

    // bytes spent in each state
    always_comb begin
        case (state_q)
            udp_tx_pkg::PREAMBLE: state_bytes = udp_tx_pkg::LEN_WIDTH'(udp_tx_pkg::PREAMBLE_BYTES);
            udp_tx_pkg::HEADER:   state_bytes = udp_tx_pkg::LEN_WIDTH'(udp_tx_pkg::HEADER_BYTES);
            udp_tx_pkg::PAYLOAD:  state_bytes = len_q;
            udp_tx_pkg::FCS:      state_bytes = udp_tx_pkg::LEN_WIDTH'(udp_tx_pkg::FCS_BYTES);
            udp_tx_pkg::GAP:      state_bytes = udp_tx_pkg::LEN_WIDTH'(udp_tx_pkg::GAP_BYTES);
            default:              state_bytes = udp_tx_pkg::LEN_WIDTH'(1);
        endcase
        state_done = (cnt_q == state_bytes - 1'b1);
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            udp_tx_pkg::IDLE: begin
                if (pkt_avail_i) begin
                    state_d = udp_tx_pkg::PREAMBLE;
                end
            end
            udp_tx_pkg::PREAMBLE: begin
                if (state_done) begin
                    state_d = udp_tx_pkg::SFD;
                end
            end
            udp_tx_pkg::SFD: begin
                state_d = udp_tx_pkg::HEADER;
            end
            udp_tx_pkg::HEADER: begin
                if (state_done) begin
                    state_d = udp_tx_pkg::PAYLOAD;
                end
            end
            udp_tx_pkg::PAYLOAD: begin
                if (state_done) begin
                    state_d = udp_tx_pkg::FCS;
                end
            end
            udp_tx_pkg::FCS: begin
                if (state_done) begin
                    state_d = udp_tx_pkg::GAP;
                end
            end
            udp_tx_pkg::GAP: begin
                if (state_done) begin
                    state_d = udp_tx_pkg::IDLE;
                end
            end
            default: state_d = udp_tx_pkg::IDLE;
        endcase
    end

    always_comb begin
        tx_en    = 1'b0;
        tx_d     = 8'h00;
        crc_en_o = 1'b0;
        case (state_q)
            udp_tx_pkg::PREAMBLE: begin
                tx_en = 1'b1;
                tx_d  = udp_tx_pkg::PREAMBLE_BYTE;
            end
            udp_tx_pkg::SFD: begin
                tx_en = 1'b1;
                tx_d  = udp_tx_pkg::SFD_BYTE;
            end
            udp_tx_pkg::HEADER: begin
                tx_en    = 1'b1;
                tx_d     = hdr_sr[$bits(hdr_sr)-1 -: 8];
                crc_en_o = 1'b1;
            end
            udp_tx_pkg::PAYLOAD: begin
                tx_en    = 1'b1;
                tx_d     = byte_i;
                crc_en_o = 1'b1;
            end
            udp_tx_pkg::FCS: begin
                tx_en = 1'b1;
                // crc settles on the first fcs cycle
                tx_d  = (cnt_q == '0) ? crc_i[7:0] : fcs_q[7:0];
            end
            default: begin
                tx_en = 1'b0;
            end
        endcase
    end

    assign crc_clear_o = (state_q == udp_tx_pkg::IDLE);
    assign crc_data_o  = tx_d;

    // fifo read is one cycle late, so fetch each byte a cycle early
    assign byte_pop_o = (state_q == udp_tx_pkg::HEADER && state_done) ||
                        (state_q == udp_tx_pkg::PAYLOAD && !state_done);
    assign len_pop_o  = (state_q == udp_tx_pkg::PAYLOAD) && state_done;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= udp_tx_pkg::IDLE;
            cnt_q   <= '0;
            gmii_o  <= '0;
        end else begin
            state_q   <= state_d;
            cnt_q     <= (state_d != state_q) ? '0 : cnt_q + 1'b1;
            gmii_o.en <= tx_en;
            gmii_o.d  <= tx_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == udp_tx_pkg::IDLE) begin
            hdr_sr <= hdr_i;
            len_q  <= pkt_len_i;
        end
        if (state_q == udp_tx_pkg::HEADER) begin
            hdr_sr <= hdr_sr << 8;
        end
        if (state_q == udp_tx_pkg::FCS) begin
            fcs_q <= ((cnt_q == '0) ? crc_i : fcs_q) >> 8;
        end
    end

endmodule

`default_nettype wire

// File: payload_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module payload_fifo (
    input  wire                     clk_i,
    input  wire                     rst_i,
    input  wire udp_tx_pkg::axis_beat_t s_axis_i,
    input  wire                     s_tvalid_i,
    output logic                    s_tready_o,
    input  wire                     byte_pop_i,
    output logic [7:0]              byte_o,
    input  wire                     len_pop_i,
    output logic                    pkt_avail_o,
    output logic [udp_tx_pkg::LEN_WIDTH-1:0] pkt_len_o
);

    logic [7:0] mem [udp_tx_pkg::FIFO_DEPTH];
    logic [udp_tx_pkg::FIFO_AW-1:0] wr_ptr;
    logic [udp_tx_pkg::FIFO_AW-1:0] rd_ptr;
    logic [udp_tx_pkg::FIFO_AW:0]   fill;
    logic [udp_tx_pkg::FIFO_AW:0]   free;

    logic [udp_tx_pkg::LEN_WIDTH-1:0] len_mem [udp_tx_pkg::LEN_QUEUE_DEPTH];
    logic [udp_tx_pkg::LQ_AW-1:0]     lq_wr;
    logic [udp_tx_pkg::LQ_AW-1:0]     lq_rd;
    logic [udp_tx_pkg::LQ_AW:0]       lq_fill;
    logic [udp_tx_pkg::LEN_WIDTH-1:0] cur_len;

    logic ready_en;
    logic in_pkt;
    logic wr;
    logic lq_push;
    logic admit;

    assign free = (udp_tx_pkg::FIFO_AW + 1)'(udp_tx_pkg::FIFO_DEPTH) - fill;

    // whole packet must fit, and its length needs a queue slot
    assign admit = (lq_fill < (udp_tx_pkg::LQ_AW + 1)'(udp_tx_pkg::LEN_QUEUE_DEPTH)) &&
                   (free >= (udp_tx_pkg::FIFO_AW + 1)'(s_axis_i.tuser));

    assign s_tready_o = ready_en && (in_pkt || admit);
    assign wr         = s_tvalid_i && s_tready_o;
    assign lq_push    = wr && s_axis_i.tlast;

    assign pkt_avail_o = (lq_fill != '0);
    assign pkt_len_o   = len_mem[lq_rd];

    always_ff @(posedge clk_i) begin
        if (wr) begin
            mem[wr_ptr] <= s_axis_i.tdata;
        end
        if (byte_pop_i) begin
            byte_o <= mem[rd_ptr];
        end
        if (wr && !in_pkt) begin
            cur_len <= s_axis_i.tuser;
        end
        if (lq_push) begin
            len_mem[lq_wr] <= in_pkt ? cur_len : s_axis_i.tuser;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ready_en <= 1'b0;
            in_pkt   <= 1'b0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill     <= '0;
            lq_wr    <= '0;
            lq_rd    <= '0;
            lq_fill  <= '0;
        end else begin
            ready_en <= 1'b1;
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
                in_pkt <= !s_axis_i.tlast;
            end
            if (byte_pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            fill <= fill + (udp_tx_pkg::FIFO_AW + 1)'(wr)
                         - (udp_tx_pkg::FIFO_AW + 1)'(byte_pop_i);
            if (lq_push) begin
                lq_wr <= lq_wr + 1'b1;
            end
            if (len_pop_i) begin
                lq_rd <= lq_rd + 1'b1;
            end
            lq_fill <= lq_fill + (udp_tx_pkg::LQ_AW + 1)'(lq_push)
                               - (udp_tx_pkg::LQ_AW + 1)'(len_pop_i);
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_udp_tx -f tb.f -o sim_udp_tx \
    && ./obj_dir/sim_udp_tx > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// File: tb.f
udp_tx_pkg.sv
payload_fifo.sv
udp_header_builder.sv
eth_crc32.sv
frame_tx_ctrl.sv
udp_tx_top.sv
tb_udp_tx.sv

// File: tb_udp_tx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_udp_tx;

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 8;
    localparam int CYCLES_PER_REC = 3000;
    localparam int MAX_REC = 32;
    localparam int MIN_IDLE = 12;

    logic clk_i;
    logic rst_i;
    udp_tx_pkg::axis_beat_t s_axis;
    logic s_tvalid;
    logic s_tready;
    udp_tx_pkg::endpoint_t local_ep;
    udp_tx_pkg::endpoint_t remote_ep;
    udp_tx_pkg::gmii_tx_t gmii;

    // one record per packet, filled from the stimulus file
    string rec_name [MAX_REC];
    int rec_len [MAX_REC];
    int rec_seed [MAX_REC];
    int rec_mode [MAX_REC];
    udp_tx_pkg::endpoint_t rec_local [MAX_REC];
    udp_tx_pkg::endpoint_t rec_remote [MAX_REC];
    logic [15:0] rec_csum [MAX_REC];
    logic [31:0] rec_residue [MAX_REC];
    int n_rec;
    logic loaded;

    integer seed;
    logic [7:0] pay_q [$];
    logic [7:0] rx_q [$];
    logic [7:0] exp_q [$];
    int sent;
    int frames_rx;
    int idle_run;
    logic stall_seen;
    int err_byte;
    int err_len;
    int err_csum;
    int err_fcs;
    int err_other;

    udp_tx_top dut (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .s_axis_i   (s_axis),
        .s_tvalid_i (s_tvalid),
        .s_tready_o (s_tready),
        .local_i    (local_ep),
        .remote_i   (remote_ep),
        .gmii_o     (gmii)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    function automatic logic [31:0] reverse32(input logic [31:0] v);
        logic [31:0] r;
        for (int i = 0; i < 32; i++) begin
            r[i] = v[31 - i];
        end
        return r;
    endfunction

    // msb-first register, each byte fed lsb first
    function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] b);
        logic [31:0] n;
        logic fb;
        n = c;
        for (int i = 0; i < 8; i++) begin
            fb = n[31] ^ b[i];
            n = n << 1;
            if (fb) begin
                n = n ^ 32'h04C1_1DB7;
            end
        end
        return n;
    endfunction

    task automatic push_field(input logic [47:0] v, input int nbytes);
        for (int i = nbytes - 1; i >= 0; i--) begin
            exp_q.push_back(v[i*8 +: 8]);
        end
    endtask

    task automatic build_frame(input int k);
        logic [31:0] c;
        logic [31:0] fcs;
        exp_q.delete();
        for (int i = 0; i < 7; i++) begin
            exp_q.push_back(8'h55);
        end
        exp_q.push_back(8'hD5);
        push_field(rec_remote[k].mac, 6);
        push_field(rec_local[k].mac, 6);
        push_field(48'h0800, 2);
        push_field(48'h4500, 2);
        push_field(48'(rec_len[k] + 28), 2);
        // id zero, dont-fragment set
        push_field(48'h0000_4000, 4);
        push_field(48'h4011, 2);
        push_field(48'(rec_csum[k]), 2);
        push_field(48'(rec_local[k].ip), 4);
        push_field(48'(rec_remote[k].ip), 4);
        push_field(48'(rec_local[k].port), 2);
        push_field(48'(rec_remote[k].port), 2);
        push_field(48'(rec_len[k] + 8), 2);
        push_field(48'h0, 2);
        for (int i = 0; i < rec_len[k] && pay_q.size() > 0; i++) begin
            exp_q.push_back(pay_q.pop_front());
        end
        c = 32'hFFFF_FFFF;
        for (int i = 8; i < exp_q.size(); i++) begin
            c = crc_step(c, exp_q[i]);
        end
        fcs = ~reverse32(c);
        for (int i = 0; i < 4; i++) begin
            exp_q.push_back(fcs[i*8 +: 8]);
        end
    endtask

    task automatic check_frame(input int k);
        logic [31:0] c;
        logic [31:0] fcs_exp;
        logic [31:0] fcs_act;
        int n;
        int first_bad;
        build_frame(k);
        if (rx_q.size() != exp_q.size()) begin
            err_len++;
            $display("Fail %s frame length: expected %0d, actual %0d",
                     rec_name[k], exp_q.size(), rx_q.size());
        end
        n = (rx_q.size() < exp_q.size()) ? rx_q.size() : exp_q.size();
        first_bad = -1;
        for (int i = 0; i < n; i++) begin
            if (rx_q[i] !== exp_q[i] && first_bad < 0) begin
                first_bad = i;
            end
        end
        if (first_bad >= 0) begin
            err_byte++;
            $display("Fail %s byte %0d: expected %02h, actual %02h",
                     rec_name[k], first_bad, exp_q[first_bad], rx_q[first_bad]);
        end
        // ipv4 checksum sits at frame bytes 32 and 33
        if (rx_q.size() >= 34 && {rx_q[32], rx_q[33]} !== rec_csum[k]) begin
            err_csum++;
            $display("Fail %s ip checksum: expected %04h, actual %04h",
                     rec_name[k], rec_csum[k], {rx_q[32], rx_q[33]});
        end
        if (rx_q.size() == exp_q.size()) begin
            fcs_exp = {exp_q[n-4], exp_q[n-3], exp_q[n-2], exp_q[n-1]};
            fcs_act = {rx_q[n-4], rx_q[n-3], rx_q[n-2], rx_q[n-1]};
            if (fcs_act !== fcs_exp) begin
                err_fcs++;
                $display("Fail %s fcs in wire order: expected %08h, actual %08h",
                         rec_name[k], fcs_exp, fcs_act);
            end
            c = 32'hFFFF_FFFF;
            for (int i = 8; i < n; i++) begin
                c = crc_step(c, rx_q[i]);
            end
            if (reverse32(c) !== rec_residue[k]) begin
                err_fcs++;
                $display("Fail %s crc residue: expected %08h, actual %08h",
                         rec_name[k], rec_residue[k], reverse32(c));
            end
        end
    endtask

    // collects each frame while en is high, sampled mid-cycle
    always @(negedge clk_i) begin
        if (!rst_i) begin
            if (gmii.en) begin
                if (rx_q.size() == 0 && frames_rx > 0 && idle_run < MIN_IDLE) begin
                    err_other++;
                    $display("Error: only %0d idle cycles before frame %0d",
                             idle_run, frames_rx);
                end
                rx_q.push_back(gmii.d);
                idle_run = 0;
            end else begin
                if (rx_q.size() > 0) begin
                    if (frames_rx >= sent) begin
                        err_other++;
                        $display("Error: a frame came out with no packet sent for it");
                    end else begin
                        check_frame(frames_rx);
                    end
                    frames_rx++;
                    rx_q.delete();
                end
                idle_run++;
            end
        end
    end

    always @(negedge clk_i) begin
        if (s_tvalid && !s_tready) begin
            stall_seen = 1'b1;
        end
    end

    task automatic load_stimulus();
        integer fd;
        integer code;
        string line;
        string name;
        int len;
        int rseed;
        int mode;
        logic [47:0] lmac;
        logic [47:0] rmac;
        logic [31:0] lip;
        logic [31:0] rip;
        logic [31:0] residue;
        logic [15:0] lport;
        logic [15:0] rport;
        logic [15:0] csum;
        n_rec = 0;
        fd = $fopen("udp_tx_stimulus.txt", "r");
        if (fd == 0) begin
            err_other++;
            $display("Error: cannot open udp_tx_stimulus.txt");
        end else begin
            while (!$feof(fd) && n_rec < MAX_REC) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line[0] != "#") begin
                    code = $sscanf(line, "%s %d %d %h %h %h %h %h %h %h %h %d",
                                   name, len, rseed, lmac, lip, lport,
                                   rmac, rip, rport, csum, residue, mode);
                    if (code == 12) begin
                        rec_name[n_rec] = name;
                        rec_len[n_rec] = len;
                        rec_seed[n_rec] = rseed;
                        rec_mode[n_rec] = mode;
                        rec_local[n_rec] = {lmac, lip, lport};
                        rec_remote[n_rec] = {rmac, rip, rport};
                        rec_csum[n_rec] = csum;
                        rec_residue[n_rec] = residue;
                        n_rec++;
                    end else begin
                        err_other++;
                        $display("Error: malformed stimulus line: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;
    endtask

    task automatic send_packet(input int k);
        logic [7:0] data [udp_tx_pkg::PAYLOAD_MAX];
        logic xfer;
        seed = seed + rec_seed[k];
        for (int i = 0; i < rec_len[k]; i++) begin
            data[i] = 8'($random(seed));
            pay_q.push_back(data[i]);
        end
        stall_seen = 1'b0;
        sent++;
        for (int i = 0; i < rec_len[k]; i++) begin
            if (rec_mode[k] == 1 && ($random(seed) & 3) == 0) begin
                s_tvalid = 1'b0;
                @(posedge clk_i);
                #1;
            end
            s_axis.tdata = data[i];
            s_axis.tlast = (i == rec_len[k] - 1);
            s_axis.tuser = (i == 0) ? udp_tx_pkg::LEN_WIDTH'(rec_len[k]) : '0;
            s_tvalid = 1'b1;
            xfer = 1'b0;
            while (!xfer) begin
                @(negedge clk_i);
                xfer = s_tready;
                @(posedge clk_i);
                #1;
            end
        end
        s_tvalid = 1'b0;
        s_axis = '0;
        if (rec_mode[k] == 2 && !stall_seen) begin
            err_other++;
            $display("Error: %s never saw s_tready drop", rec_name[k]);
        end
    endtask

    task automatic wait_drain();
        while (frames_rx < sent) begin
            @(posedge clk_i);
        end
        repeat (4) @(posedge clk_i);
        #1;
    endtask

    initial begin
        int total;
        rst_i = 1'b1;
        s_tvalid = 1'b0;
        s_axis = '0;
        local_ep = '0;
        remote_ep = '0;
        loaded = 1'b0;
        seed = 946;
        sent = 0;
        frames_rx = 0;
        idle_run = 0;
        stall_seen = 1'b0;
        err_byte = 0;
        err_len = 0;
        err_csum = 0;
        err_fcs = 0;
        err_other = 0;
        load_stimulus();
        if (n_rec == 0) begin
            err_other++;
            $display("Error: no stimulus records were loaded");
        end
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        if (gmii.en !== 1'b0 || s_tready !== 1'b0) begin
            err_other++;
            $display("Error: en or s_tready high in the first cycle after reset");
        end
        // quiet period, the monitor flags any frame here
        repeat (20) @(posedge clk_i);
        #1;
        if (s_tready !== 1'b1) begin
            err_other++;
            $display("Error: s_tready stays low with an empty buffer");
        end
        for (int k = 0; k < n_rec; k++) begin
            if (k == 0 || rec_local[k] != local_ep || rec_remote[k] != remote_ep) begin
                wait_drain();
                local_ep = rec_local[k];
                remote_ep = rec_remote[k];
            end
            send_packet(k);
        end
        wait_drain();
        repeat (20) @(posedge clk_i);
        total = err_byte + err_len + err_csum + err_fcs + err_other;
        $display("errors: byte %0d, length %0d, checksum %0d, fcs %0d, other %0d",
                 err_byte, err_len, err_csum, err_fcs, err_other);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        wait (loaded === 1'b1);
        repeat (n_rec * CYCLES_PER_REC + RESET_CYCLES + 100) @(posedge clk_i);
        $display("Error: timeout with %0d of %0d frames received", frames_rx, n_rec);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: udp_header_builder.sv
`timescale 1ns/1ps
`default_nettype none

module udp_header_builder (
    input  wire udp_tx_pkg::endpoint_t       local_i,
    input  wire udp_tx_pkg::endpoint_t       remote_i,
    input  wire [udp_tx_pkg::LEN_WIDTH-1:0]  payload_len_i,
    output udp_tx_pkg::frame_hdr_t           hdr_o
);

    udp_tx_pkg::frame_hdr_t hdr;
    logic [15:0] payload_len;
    logic [19:0] sum;
    logic [16:0] fold;
    logic [15:0] csum;

    assign payload_len = 16'(payload_len_i);

    always_comb begin
        hdr = '0;

        // ethernet
        hdr.eth_dst   = remote_i.mac;
        hdr.eth_src   = local_i.mac;
        hdr.ethertype = udp_tx_pkg::ETHERTYPE_IPV4;

        // ipv4, 20 bytes, no options
        hdr.ip_ver_ihl    = 8'h45;
        hdr.ip_tos        = 8'h00;
        hdr.ip_total_len  = payload_len + 16'd28;
        hdr.ip_id         = 16'h0000;
        hdr.ip_flags_frag = udp_tx_pkg::IP_FLAGS_DF;
        hdr.ip_ttl        = udp_tx_pkg::IP_TTL;
        hdr.ip_proto      = udp_tx_pkg::IP_PROTO_UDP;
        hdr.ip_src        = local_i.ip;
        hdr.ip_dst        = remote_i.ip;

        // udp, checksum left at zero
        hdr.udp_src_port = local_i.port;
        hdr.udp_dst_port = remote_i.port;
        hdr.udp_length   = payload_len + 16'd8;
        hdr.udp_checksum = 16'h0000;

        // ten header words, checksum word taken as zero
        sum = 20'({hdr.ip_ver_ihl, hdr.ip_tos})
            + 20'(hdr.ip_total_len)
            + 20'(hdr.ip_id)
            + 20'(hdr.ip_flags_frag)
            + 20'({hdr.ip_ttl, hdr.ip_proto})
            + 20'(hdr.ip_src[31:16])
            + 20'(hdr.ip_src[15:0])
            + 20'(hdr.ip_dst[31:16])
            + 20'(hdr.ip_dst[15:0]);

        // end-around carry, twice covers any carry out of the first fold
        fold = 17'(sum[15:0]) + 17'(sum[19:16]);
        csum = fold[15:0] + 16'(fold[16]);

        hdr.ip_checksum = ~csum;
    end

    assign hdr_o = hdr;

endmodule

`default_nettype wire

// File: udp_tx_pkg.sv
`default_nettype none

package udp_tx_pkg;

    // frame layout, in bytes
    localparam int PREAMBLE_BYTES = 7;
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE = 8'hD5;
    localparam int HEADER_BYTES = 42;
    localparam int FCS_BYTES = 4;
    localparam int GAP_BYTES = 12;

    // payload buffering
    localparam int FIFO_DEPTH = 2048;
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);
    localparam int PAYLOAD_MIN = 18;
    localparam int PAYLOAD_MAX = 1024;
    localparam int LEN_WIDTH = $clog2(PAYLOAD_MAX + 1);
    localparam int LEN_QUEUE_DEPTH = 4;
    localparam int LQ_AW = $clog2(LEN_QUEUE_DEPTH);

    // fixed header fields
    localparam logic [7:0] IP_TTL = 8'd64;
    localparam logic [7:0] IP_PROTO_UDP = 8'd17;
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [15:0] IP_FLAGS_DF = 16'h4000;

    // reflected form of 0x04C11DB7
    localparam logic [31:0] CRC32_POLY_REFL = 32'hEDB88320;

    typedef struct packed {
        logic [47:0] mac;
        logic [31:0] ip;
        logic [15:0] port;
    } endpoint_t;

    // first field goes out first, msb first
    typedef struct packed {
        logic [47:0] eth_dst;
        logic [47:0] eth_src;
        logic [15:0] ethertype;
        logic [7:0]  ip_ver_ihl;
        logic [7:0]  ip_tos;
        logic [15:0] ip_total_len;
        logic [15:0] ip_id;
        logic [15:0] ip_flags_frag;
        logic [7:0]  ip_ttl;
        logic [7:0]  ip_proto;
        logic [15:0] ip_checksum;
        logic [31:0] ip_src;
        logic [31:0] ip_dst;
        logic [15:0] udp_src_port;
        logic [15:0] udp_dst_port;
        logic [15:0] udp_length;
        logic [15:0] udp_checksum;
    } frame_hdr_t;

    typedef struct packed {
        logic [7:0]           tdata;
        logic                 tlast;
        logic [LEN_WIDTH-1:0] tuser;
    } axis_beat_t;

    typedef struct packed {
        logic       en;
        logic [7:0] d;
    } gmii_tx_t;

    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        SFD,
        HEADER,
        PAYLOAD,
        FCS,
        GAP
    } tx_state_e;

endpackage

`default_nettype wire

// File: udp_tx_stimulus.txt
# name len seed local_mac local_ip local_port remote_mac remote_ip remote_port
# ip_csum crc_residue mode (0 plain, 1 random valid gaps, 2 back-pressure expected)
single_min 18 1 02000000000a c0a8010a 1388 020000000014 c0a80114 1389 b750 debb20e3 0
single_mid 100 2 020000000b01 0a000001 0400 020000000bfe 0a0000fe 0401 256f debb20e3 0
b2b_a 64 3 020000000c05 ac100505 c000 020000000cff ac10ff01 0035 de69 debb20e3 0
b2b_b 19 4 020000000c05 ac100505 c000 020000000cff ac10ff01 0035 de96 debb20e3 0
b2b_c 257 5 020000000c05 ac100505 c000 020000000cff ac10ff01 0035 dda8 debb20e3 0
gaps_a 200 6 02000000000a c0a8010a 1388 020000000014 c0a80114 1389 b69a debb20e3 1
gaps_b 33 7 02000000000a c0a8010a 1388 020000000014 c0a80114 1389 b741 debb20e3 1
bp_0 1024 8 020000000b01 0a000001 0400 020000000bfe 0a0000fe 0401 21d3 debb20e3 0
bp_1 1024 9 020000000b01 0a000001 0400 020000000bfe 0a0000fe 0401 21d3 debb20e3 0
bp_2 1024 10 020000000b01 0a000001 0400 020000000bfe 0a0000fe 0401 21d3 debb20e3 2
bp_3 1024 11 020000000b01 0a000001 0400 020000000bfe 0a0000fe 0401 21d3 debb20e3 2
single_big 1023 12 020000000c05 ac100505 c000 020000000cff ac10ff01 0035 daaa debb20e3 0

// File: udp_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module udp_tx_top (
    input  wire                          clk_i,
    input  wire                          rst_i,
    input  wire udp_tx_pkg::axis_beat_t  s_axis_i,
    input  wire                          s_tvalid_i,
    output logic                         s_tready_o,
    input  wire udp_tx_pkg::endpoint_t   local_i,
    input  wire udp_tx_pkg::endpoint_t   remote_i,
    output udp_tx_pkg::gmii_tx_t         gmii_o
);

    logic                             pkt_avail;
    logic [udp_tx_pkg::LEN_WIDTH-1:0] pkt_len;
    logic                             len_pop;
    logic                             byte_pop;
    logic [7:0]                       fifo_byte;
    udp_tx_pkg::frame_hdr_t           hdr;
    logic                             crc_clear;
    logic                             crc_en;
    logic [7:0]                       crc_data;
    logic [31:0]                      crc;

    payload_fifo u_payload_fifo (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .s_axis_i    (s_axis_i),
        .s_tvalid_i  (s_tvalid_i),
        .s_tready_o  (s_tready_o),
        .byte_pop_i  (byte_pop),
        .byte_o      (fifo_byte),
        .len_pop_i   (len_pop),
        .pkt_avail_o (pkt_avail),
        .pkt_len_o   (pkt_len)
    );

    // header follows the length at the head of the queue
    udp_header_builder u_header_builder (
        .local_i       (local_i),
        .remote_i      (remote_i),
        .payload_len_i (pkt_len),
        .hdr_o         (hdr)
    );

    eth_crc32 u_crc (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .clear_i (crc_clear),
        .en_i    (crc_en),
        .data_i  (crc_data),
        .crc_o   (crc)
    );

    frame_tx_ctrl u_ctrl (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .pkt_avail_i (pkt_avail),
        .pkt_len_i   (pkt_len),
        .len_pop_o   (len_pop),
        .byte_pop_o  (byte_pop),
        .byte_i      (fifo_byte),
        .hdr_i       (hdr),
        .crc_clear_o (crc_clear),
        .crc_en_o    (crc_en),
        .crc_data_o  (crc_data),
        .crc_i       (crc),
        .gmii_o      (gmii_o)
    );

endmodule

`default_nettype wire
